// File: all.f
+incdir+include
hw/mem_pkg.sv
hw/mem_bus_if.sv
hw/lsu_access.sv
hw/fetch_access.sv
hw/bus_arbiter.sv
hw/mem_subsystem_top.sv
verification/tb_mem_subsystem.sv

// File: Bender.yml
package:
  name: mem_subsystem

export_include_dirs:
  - include

sources:
  - files:
      - hw/mem_pkg.sv
      - hw/mem_bus_if.sv
      - hw/lsu_access.sv
      - hw/fetch_access.sv
      - hw/bus_arbiter.sv
      - hw/mem_subsystem_top.sv
  - target: simulation
    files:
      - verification/tb_mem_subsystem.sv

// File: verification/tb_mem_subsystem.sv
`timescale 1ns/1ns
`include "mem_config.svh"

module tb_mem_subsystem import mem_pkg::*; ();

    localparam int          MEM_WORDS      = 64;       // addresses 0x000 .. 0x1ff
    localparam int          TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] SEED           = 32'h70c41a76;

    logic           clk;
    logic           rst;
    logic           intp_en_i;
    logic           inst_valid_i;
    logic           mem_write_i;
    logic           mem_read_i;
    store_type_t    store_type_i;
    load_type_t     load_type_i;
    addr_t          data_addr_i;
    xdata_t         write_data_i;
    xdata_t         read_data_o;
    logic           access_ok_o;
    logic           access_fault_o;
    logic           fetch_valid_i;
    addr_t          fetch_pc_i;
    instr_t         fetch_instr_o;
    logic           fetch_done_o;
    logic           bus_valid_o;
    logic           bus_ready_i;
    addr_t          bus_addr_o;
    xdata_t         bus_wdata_o;
    access_size_t   bus_size_o;
    bus_req_t       bus_req_o;
    xdata_t         bus_rdata_i;
    bus_resp_t      bus_resp_i;

    xdata_t         mem [MEM_WORDS];        // contents seen by the bus
    xdata_t         shadow [MEM_WORDS];     // contents expected from the stores issued
    int             delay_tab [256];
    int             delay_idx;
    int             wait_left;
    logic           waiting;
    logic           next_ready;
    xdata_t         next_rdata;
    bus_resp_t      next_resp;
    logic           inject_err;
    addr_t          hs_log [$];
    int             cycle_count;
    int             error_count;

    mem_subsystem_top UUT (
        .clk            (clk),
        .rst            (rst),
        .intp_en_i      (intp_en_i),
        .inst_valid_i   (inst_valid_i),
        .mem_write_i    (mem_write_i),
        .mem_read_i     (mem_read_i),
        .store_type_i   (store_type_i),
        .load_type_i    (load_type_i),
        .data_addr_i    (data_addr_i),
        .write_data_i   (write_data_i),
        .read_data_o    (read_data_o),
        .access_ok_o    (access_ok_o),
        .access_fault_o (access_fault_o),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_pc_i     (fetch_pc_i),
        .fetch_instr_o  (fetch_instr_o),
        .fetch_done_o   (fetch_done_o),
        .bus_valid_o    (bus_valid_o),
        .bus_ready_i    (bus_ready_i),
        .bus_addr_o     (bus_addr_o),
        .bus_wdata_o    (bus_wdata_o),
        .bus_size_o     (bus_size_o),
        .bus_req_o      (bus_req_o),
        .bus_rdata_i    (bus_rdata_i),
        .bus_resp_i     (bus_resp_i)
    );

    always #4 clk = ~clk;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    task automatic fail_run();
        error_count++;
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(string name, xdata_t got, xdata_t expected);
        assert (got === expected) else begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected);
            fail_run();
        end
    endtask

    function automatic xdata_t fill_word(int unsigned index);
        return {index * 32'h9e37_79b9, ~(index * 32'h85eb_ca6b)} ^ 64'ha5c3_0f1e_96d2_4b78;
    endfunction

    // addressed bytes brought down to bit 0, then extended as the load type asks
    function automatic xdata_t expected_load(xdata_t word, logic [2:0] off, load_type_t ltype);
        int     nbytes;
        xdata_t value;
        logic   fill;
        case (ltype[1:0])
            2'b01:   nbytes = 1;
            2'b10:   nbytes = 2;
            2'b11:   nbytes = 4;
            default: nbytes = 8;
        endcase
        value = '0;
        for (int i = 0; i < nbytes; i++) begin
            value[i*8 +: 8] = word[(off + i)*8 +: 8];
        end
        fill = value[nbytes*8 - 1] & ~ltype[2];
        for (int b = nbytes*8; b < 64; b++) begin
            value[b] = fill;
        end
        return value;
    endfunction

    //////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////
    task automatic write_lanes();
        int nbytes;
        int off;
        int idx;
        nbytes = 1 << bus_size_o;
        off    = bus_addr_o[2:0];
        idx    = bus_addr_o[8:3];
        for (int i = 0; i < nbytes && off + i < 8; i++) begin
            mem[idx][(off + i)*8 +: 8] = bus_wdata_o[(off + i)*8 +: 8];
        end
    endtask

    always begin
        @(posedge clk);                                 // values from before the edge
        next_ready = 1'b0;
        if (!rst && bus_valid_o && bus_ready_i) begin
            hs_log.push_back(bus_addr_o);
            if (bus_req_o == `REQ_WRITE) begin
                write_lanes();
            end
            waiting = 1'b0;
        end else if (!rst && bus_valid_o) begin
            if (!waiting) begin
                wait_left = delay_tab[delay_idx % 256];
                delay_idx++;
                waiting   = 1'b1;
            end
            if (wait_left == 0) begin
                next_ready = 1'b1;
                next_rdata = mem[bus_addr_o[8:3]];    // whole word, lanes untouched
                next_resp  = inject_err ? 2'd2 : `RESP_OKAY;
            end else begin
                wait_left--;
            end
        end else begin
            waiting = 1'b0;
        end
        @(negedge clk);
        bus_ready_i = next_ready;
        bus_rdata_i = next_rdata;
        bus_resp_i  = next_resp;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a handshake or done flag never came", cycle_count);
            fail_run();
        end
    end

    //////////////////////////////////////////////////
    // access tasks
    //////////////////////////////////////////////////
    task automatic start_instruction();
        @(negedge clk);
        inst_valid_i = 1'b1;
        @(negedge clk);
        inst_valid_i = 1'b0;
        check_value("access_ok_o", access_ok_o, 1'b0);
        check_value("access_fault_o", access_fault_o, 1'b0);
    endtask

    task automatic wait_access_ok();
        do @(negedge clk); while (access_ok_o !== 1'b1);
    endtask

    task automatic store_data(addr_t addr, xdata_t data, access_size_t size);
        int nbytes;
        int idx;
        nbytes = 1 << size;
        idx    = addr[8:3];
        start_instruction();
        mem_write_i  = 1'b1;
        store_type_i = {1'b1, size};
        data_addr_i  = addr;
        write_data_i = data;
        wait_access_ok();
        check_value("access_fault_o", access_fault_o, inject_err);
        mem_write_i  = 1'b0;
        for (int i = 0; i < nbytes; i++) begin
            shadow[idx][(addr[2:0] + i)*8 +: 8] = data[i*8 +: 8];
        end
    endtask

    task automatic load_check(addr_t addr, load_type_t ltype);
        start_instruction();
        mem_read_i  = 1'b1;
        load_type_i = ltype;
        data_addr_i = addr;
        wait_access_ok();
        check_value("read_data_o", read_data_o,
                    expected_load(shadow[addr[8:3]], addr[2:0], ltype));
        check_value("access_fault_o", access_fault_o, inject_err);
        mem_read_i  = 1'b0;
    endtask

    task automatic fetch_check(addr_t pc);
        xdata_t word;
        word = shadow[pc[8:3]];
        @(negedge clk);
        fetch_valid_i = 1'b1;
        fetch_pc_i    = pc;
        @(negedge clk);
        fetch_valid_i = 1'b0;
        check_value("fetch_done_o", fetch_done_o, 1'b0);
        do @(negedge clk); while (fetch_done_o !== 1'b1);
        check_value("fetch_instr_o", fetch_instr_o, word[pc[2:0]*8 +: 32]);
        @(negedge clk);
        check_value("fetch_done_o", fetch_done_o, 1'b1);
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////
    task automatic test_store_merge();
        int     word;
        int     off;
        addr_t  addr;
        for (int rep = 0; rep < 3; rep++) begin
            for (int s = 0; s < 4; s++) begin
                word = $urandom_range(MEM_WORDS - 1, 0);
                off  = $urandom_range(7, 0) & ~((1 << s) - 1);   // aligned to the size
                addr = addr_t'(word * 8 + off);
                store_data(addr, {$urandom, $urandom}, access_size_t'(s));
                load_check({addr[31:3], 3'b000}, 3'b100);
            end
        end
    endtask

    task automatic test_load_extend();
        addr_t base;
        base = 32'h0000_00c0;
        store_data(base, 64'h708c_fa31_8e05_61d2, `SIZE_D);  // mixed sign bits in every width
        for (int off = 0; off < 8; off++) begin
            load_check(base + off, 3'b001);
            load_check(base + off, 3'b101);
        end
        for (int off = 0; off < 8; off += 2) begin
            load_check(base + off, 3'b010);
            load_check(base + off, 3'b110);
        end
        for (int off = 0; off < 8; off += 4) begin
            load_check(base + off, 3'b011);
            load_check(base + off, 3'b111);
        end
    endtask

    task automatic test_fetch_halves();
        fetch_check(32'h0000_0100);
        fetch_check(32'h0000_0104);
        fetch_check(32'h0000_00c0);
        fetch_check(32'h0000_00c4);
    endtask

    task automatic test_data_and_fetch();
        addr_t  daddr;
        addr_t  pc;
        logic   data_seen;
        logic   fetch_seen;
        daddr = 32'h0000_0048;
        pc    = 32'h0000_0084;
        start_instruction();
        hs_log.delete();
        fetch_valid_i = 1'b1;                           // the fetch pulse leads by one cycle
        fetch_pc_i    = pc;
        @(negedge clk);
        fetch_valid_i = 1'b0;
        mem_read_i    = 1'b1;                           // both requests now meet at the arbiter
        load_type_i   = 3'b100;
        data_addr_i   = daddr;
        data_seen     = 1'b0;
        fetch_seen    = 1'b0;
        while (!(data_seen && fetch_seen)) begin
            @(negedge clk);
            if (access_ok_o) data_seen = 1'b1;
            if (fetch_done_o) fetch_seen = 1'b1;
        end
        assert (hs_log.size() == 2 && hs_log[0] == daddr) else begin
            $display("the data request was not the first of exactly two bus transfers");
            fail_run();
        end
        check_value("read_data_o", read_data_o, shadow[daddr[8:3]]);
        check_value("fetch_instr_o", fetch_instr_o, shadow[pc[8:3]][63:32]);
        mem_read_i = 1'b0;
    endtask

    task automatic test_interrupt_cancel();
        addr_t addr;
        addr = 32'h0000_0130;
        start_instruction();
        intp_en_i    = 1'b1;
        mem_write_i  = 1'b1;
        store_type_i = {1'b1, `SIZE_D};
        data_addr_i  = addr;
        write_data_i = 64'hdead_beef_0bad_f00d;
        #1;
        check_value("access_ok_o", access_ok_o, 1'b1);
        check_value("bus_valid_o", bus_valid_o, 1'b0);
        repeat (3) begin
            @(negedge clk);
            check_value("access_ok_o", access_ok_o, 1'b1);
            check_value("bus_valid_o", bus_valid_o, 1'b0);
        end
        intp_en_i   = 1'b0;
        mem_write_i = 1'b0;
        load_check(addr, 3'b100);                       // the cancelled store left no trace
        store_data(addr, 64'h0123_4567_89ab_cdef, `SIZE_D);
        load_check(addr, 3'b100);
    endtask

    task automatic test_error_response();
        inject_err = 1'b1;
        load_check(32'h0000_0018, 3'b011);
        inject_err = 1'b0;
        load_check(32'h0000_0018, 3'b011);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        void'($urandom(SEED));
        for (int i = 0; i < 256; i++) begin
            delay_tab[i] = $urandom_range(3, 0);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]    = fill_word(i);
            shadow[i] = fill_word(i);
        end
        clk           = 1'b0;
        rst           = 1'b1;
        intp_en_i     = 1'b0;
        inst_valid_i  = 1'b0;
        mem_write_i   = 1'b0;
        mem_read_i    = 1'b0;
        store_type_i  = '0;
        load_type_i   = 3'b100;
        data_addr_i   = '0;
        write_data_i  = '0;
        fetch_valid_i = 1'b0;
        fetch_pc_i    = '0;
        bus_ready_i   = 1'b0;
        bus_rdata_i   = '0;
        bus_resp_i    = `RESP_OKAY;
        next_rdata    = '0;
        next_resp     = `RESP_OKAY;
        waiting       = 1'b0;
        delay_idx     = 0;
        wait_left     = 0;
        inject_err    = 1'b0;
        cycle_count   = 0;
        error_count   = 0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("bus_valid_o", bus_valid_o, 1'b0);
        check_value("access_ok_o", access_ok_o, 1'b0);
        check_value("fetch_done_o", fetch_done_o, 1'b0);
        check_value("access_fault_o", access_fault_o, 1'b0);

        test_store_merge();
        test_load_extend();
        test_fetch_halves();
        test_data_and_fetch();
        test_interrupt_cancel();
        test_error_response();

        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: hw/mem_subsystem_top.sv
`timescale 1ns/1ns

module mem_subsystem_top import mem_pkg::*; (
    input  logic            clk,
    input  logic            rst,

    // load/store side
    input  logic            intp_en_i,
    input  logic            inst_valid_i,
    input  logic            mem_write_i,
    input  logic            mem_read_i,
    input  store_type_t     store_type_i,
    input  load_type_t      load_type_i,
    input  addr_t           data_addr_i,
    input  xdata_t          write_data_i,
    output xdata_t          read_data_o,
    output logic            access_ok_o,
    output logic            access_fault_o,

    // fetch side
    input  logic            fetch_valid_i,
    input  addr_t           fetch_pc_i,
    output instr_t          fetch_instr_o,
    output logic            fetch_done_o,

    // external memory bus
    output logic            bus_valid_o,
    input  logic            bus_ready_i,
    output addr_t           bus_addr_o,
    output xdata_t          bus_wdata_o,
    output access_size_t    bus_size_o,
    output bus_req_t        bus_req_o,
    input  xdata_t          bus_rdata_i,
    input  bus_resp_t       bus_resp_i
);

    mem_bus_if data_bus ();
    mem_bus_if fetch_bus ();

    lsu_access u_lsu (
        .clk            (clk),
        .rst            (rst),
        .intp_en_i      (intp_en_i),
        .inst_valid_i   (inst_valid_i),
        .mem_write_i    (mem_write_i),
        .mem_read_i     (mem_read_i),
        .store_type_i   (store_type_i),
        .load_type_i    (load_type_i),
        .data_addr_i    (data_addr_i),
        .write_data_i   (write_data_i),
        .read_data_o    (read_data_o),
        .access_ok_o    (access_ok_o),
        .access_fault_o (access_fault_o),
        .bus            (data_bus.requester)
    );

    fetch_access u_fetch (
        .clk            (clk),
        .rst            (rst),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_pc_i     (fetch_pc_i),
        .fetch_instr_o  (fetch_instr_o),
        .fetch_done_o   (fetch_done_o),
        .bus            (fetch_bus.requester)
    );

    bus_arbiter u_arb (
        .clk            (clk),
        .rst            (rst),
        .data_bus       (data_bus.arbiter),
        .fetch_bus      (fetch_bus.arbiter),
        .bus_valid_o    (bus_valid_o),
        .bus_ready_i    (bus_ready_i),
        .bus_addr_o     (bus_addr_o),
        .bus_wdata_o    (bus_wdata_o),
        .bus_size_o     (bus_size_o),
        .bus_req_o      (bus_req_o),
        .bus_rdata_i    (bus_rdata_i),
        .bus_resp_i     (bus_resp_i)
    );

endmodule

// File: hw/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter import mem_pkg::*; (
    input  logic            clk,
    input  logic            rst,

    mem_bus_if.arbiter      data_bus,
    mem_bus_if.arbiter      fetch_bus,

    output logic            bus_valid_o,
    input  logic            bus_ready_i,
    output addr_t           bus_addr_o,
    output xdata_t          bus_wdata_o,
    output access_size_t    bus_size_o,
    output bus_req_t        bus_req_o,
    input  xdata_t          bus_rdata_i,
    input  bus_resp_t       bus_resp_i
);

    arb_state_e state;
    arb_state_e state_n;
    logic       sel_data;

    //////////////////////////////////////////////////
    // owner select
    //////////////////////////////////////////////////
    always_comb begin
        case (state)
            ARB_DATA:  sel_data = 1'b1;
            ARB_FETCH: sel_data = 1'b0;
            default:   sel_data = data_bus.valid;       // data side wins a tie
        endcase
    end

    always_comb begin
        state_n = state;
        case (state)
            ARB_IDLE: begin
                if (bus_valid_o && !bus_ready_i) begin
                    state_n = sel_data ? ARB_DATA : ARB_FETCH;
                end
            end
            ARB_DATA: begin
                // an interrupt can withdraw the data request, which frees the bus too
                if (bus_ready_i || !data_bus.valid) begin
                    state_n = ARB_IDLE;
                end
            end
            ARB_FETCH: begin
                if (bus_ready_i) begin
                    state_n = ARB_IDLE;
                end
            end
            default: state_n = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_n;
        end
    end

    //////////////////////////////////////////////////
    // request mux and response fan-out
    //////////////////////////////////////////////////
    assign bus_valid_o = sel_data ? data_bus.valid : fetch_bus.valid;
    assign bus_addr_o  = sel_data ? data_bus.addr  : fetch_bus.addr;
    assign bus_wdata_o = sel_data ? data_bus.wdata : fetch_bus.wdata;
    assign bus_size_o  = sel_data ? data_bus.size  : fetch_bus.size;
    assign bus_req_o   = sel_data ? data_bus.req   : fetch_bus.req;

    assign data_bus.ready  = sel_data & bus_ready_i;    // the loser just sees a stall
    assign fetch_bus.ready = ~sel_data & bus_ready_i;

    assign data_bus.rdata  = bus_rdata_i;
    assign data_bus.resp   = bus_resp_i;
    assign fetch_bus.rdata = bus_rdata_i;
    assign fetch_bus.resp  = bus_resp_i;

    // a stalled transfer keeps its owner until ready
    a_owner_locked : assert property (
        @(posedge clk) disable iff (rst)
        (bus_valid_o && !bus_ready_i) |=> $stable(sel_data)
    );

endmodule

// File: hw/fetch_access.sv
`timescale 1ns/1ns
`include "mem_config.svh"

module fetch_access import mem_pkg::*; (
    input  logic            clk,
    input  logic            rst,

    input  logic            fetch_valid_i,
    input  addr_t           fetch_pc_i,
    output instr_t          fetch_instr_o,
    output logic            fetch_done_o,

    mem_bus_if.requester    bus
);

    addr_t  pc_r;
    logic   pending;
    logic   handshake;

    //////////////////////////////////////////////////
    // request side
    //////////////////////////////////////////////////
    assign bus.valid = pending;
    assign bus.addr  = pc_r;
    assign bus.wdata = '0;                  // fetches never write
    assign bus.size  = `SIZE_W;
    assign bus.req   = `REQ_READ;

    assign handshake = bus.valid & bus.ready;

    always_ff @(posedge clk) begin
        if (fetch_valid_i) begin
            pc_r <= fetch_pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (fetch_valid_i) begin
            pending <= 1'b1;                // valid goes up the cycle after the pulse
        end else if (handshake) begin
            pending <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // response side
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (handshake) begin
            // pc bit 2 picks the word half of the doubleword lane
            fetch_instr_o <= pc_r[2] ? bus.rdata[63:32] : bus.rdata[31:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || fetch_valid_i) begin
            fetch_done_o <= 1'b0;
        end else if (handshake) begin
            fetch_done_o <= 1'b1;
        end
    end

    // a fetch pulse carries a word aligned program counter
    a_fetch_aligned : assert property (
        @(posedge clk) disable iff (rst)
        fetch_valid_i |-> (fetch_pc_i[1:0] == 2'b00)
    );

endmodule

// File: hw/lsu_access.sv
`timescale 1ns/1ns
`include "mem_config.svh"

module lsu_access import mem_pkg::*; (
    input  logic            clk,
    input  logic            rst,

    input  logic            intp_en_i,
    input  logic            inst_valid_i,
    input  logic            mem_write_i,
    input  logic            mem_read_i,
    input  store_type_t     store_type_i,
    input  load_type_t      load_type_i,
    input  addr_t           data_addr_i,
    input  xdata_t          write_data_i,
    output xdata_t          read_data_o,
    output logic            access_ok_o,
    output logic            access_fault_o,

    mem_bus_if.requester    bus
);

    logic           finished;
    logic           handshake;
    logic           load_unsigned;
    logic           sign_bit;
    logic [5:0]     lane_shift;
    access_size_t   load_size;
    xdata_t         width_mask;
    xdata_t         read_raw;

    //////////////////////////////////////////////////
    // request side
    //////////////////////////////////////////////////
    assign lane_shift = {data_addr_i[2:0], 3'b000};     // byte offset in bits

    always_comb begin
        case (load_type_i[1:0])
            2'b01: begin
                load_size  = `SIZE_B;
                width_mask = 64'h0000_0000_0000_00ff;
            end
            2'b10: begin
                load_size  = `SIZE_H;
                width_mask = 64'h0000_0000_0000_ffff;
            end
            2'b11: begin
                load_size  = `SIZE_W;
                width_mask = 64'h0000_0000_ffff_ffff;
            end
            default: begin
                load_size  = `SIZE_D;                   // 3'b100, the full doubleword
                width_mask = '1;
            end
        endcase
    end

    assign bus.valid = (mem_write_i | mem_read_i) & ~finished & ~intp_en_i;
    assign bus.addr  = data_addr_i;
    assign bus.wdata = write_data_i << lane_shift;
    assign bus.size  = (mem_write_i & store_type_i[2]) ? store_type_i[1:0] : load_size;
    assign bus.req   = mem_write_i ? `REQ_WRITE : `REQ_READ;

    assign handshake = bus.valid & bus.ready;

    //////////////////////////////////////////////////
    // response side
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (handshake && mem_read_i) begin
            read_raw <= bus.rdata >> lane_shift;        // bring the addressed bytes to bit 0
        end
    end

    assign load_unsigned = load_type_i[2];

    always_comb begin
        case (load_size)
            `SIZE_B: sign_bit = read_raw[7];
            `SIZE_H: sign_bit = read_raw[15];
            `SIZE_W: sign_bit = read_raw[31];
            default: sign_bit = read_raw[63];
        endcase
    end

    // upper bytes of the shifted word belong to neighbours and are replaced
    assign read_data_o = (read_raw & width_mask)
                       | ({`XLEN{sign_bit & ~load_unsigned}} & ~width_mask);

    always_ff @(posedge clk) begin
        if (rst || inst_valid_i) begin
            finished <= 1'b0;
        end else if (handshake) begin
            finished <= 1'b1;                           // held until the next instruction
        end
    end

    always_ff @(posedge clk) begin
        if (rst || inst_valid_i) begin
            access_fault_o <= 1'b0;
        end else if (handshake && bus.resp != `RESP_OKAY) begin
            access_fault_o <= 1'b1;
        end
    end

    // a pending interrupt cancels the access and reports it done at once
    assign access_ok_o = finished | intp_en_i;

    // once on the bus the request holds until ready, unless an interrupt cancels it
    a_req_hold : assert property (
        @(posedge clk) disable iff (rst)
        (bus.valid && !bus.ready && !intp_en_i) |=>
            (intp_en_i || (bus.valid && $stable(bus.addr)))
    );

endmodule

// File: hw/mem_bus_if.sv
`timescale 1ns/1ns

interface mem_bus_if import mem_pkg::*; ();

    logic           valid;
    logic           ready;
    addr_t          addr;
    xdata_t         wdata;          // already placed in its byte lanes
    access_size_t   size;
    bus_req_t       req;
    xdata_t         rdata;          // arrives in the lane of its address
    bus_resp_t      resp;

    modport requester (
        output valid,
        output addr,
        output wdata,
        output size,
        output req,
        input  ready,
        input  rdata,
        input  resp
    );

    modport arbiter (
        input  valid,
        input  addr,
        input  wdata,
        input  size,
        input  req,
        output ready,
        output rdata,
        output resp
    );

endinterface

// File: hw/mem_pkg.sv
`include "mem_config.svh"

package mem_pkg;

    //////////////////////////////////////////////////
    // data path vectors
    //////////////////////////////////////////////////
    typedef logic [`XLEN-1:0]    xdata_t;
    typedef logic [`ADDR_W-1:0]  addr_t;
    typedef logic [`INSTR_W-1:0] instr_t;

    //////////////////////////////////////////////////
    // bus control fields
    //////////////////////////////////////////////////
    typedef logic [1:0]          access_size_t;     // SIZE_B .. SIZE_D
    typedef logic                bus_req_t;         // REQ_READ or REQ_WRITE
    typedef logic [`RESP_W-1:0]  bus_resp_t;

    // bit 2 marks unsigned, bits 1:0 give byte/half/word, 3'b100 is a doubleword
    typedef logic [`TYPE_W-1:0]  load_type_t;

    // bit 2 enables the store, bits 1:0 follow the size codes
    typedef logic [`TYPE_W-1:0]  store_type_t;

    //////////////////////////////////////////////////
    // arbiter FSM
    //////////////////////////////////////////////////
    typedef enum logic [1:0] {
        ARB_IDLE,                                   // no owner, data side has priority
        ARB_DATA,                                   // bus locked to the load/store unit
        ARB_FETCH                                   // bus locked to the fetch unit
    } arb_state_e;

endpackage

// File: include/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

//////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////
`define XLEN        64          // data path width
`define ADDR_W      32          // byte address width
`define INSTR_W     32          // one instruction word
`define TYPE_W      3           // load and store type codes
`define RESP_W      2           // bus response width

//////////////////////////////////////////////////
// bus codes
//////////////////////////////////////////////////
`define SIZE_B      2'd0        // byte access
`define SIZE_H      2'd1        // halfword access
`define SIZE_W      2'd2        // word access
`define SIZE_D      2'd3        // doubleword access

`define REQ_READ    1'b0
`define REQ_WRITE   1'b1

`define RESP_OKAY   2'd0        // anything else counts as a fault

`endif
